// File: design/alu.sv
`timescale 1ns/1ps

module alu (
	input ex_pkg::word_t a,
	input ex_pkg::word_t b,
	input ex_pkg::alu_op_t op,
	output ex_pkg::word_t result,
	output logic zero,
	output logic carry
);

	logic [4:0] shamt;
	logic [32:0] sum_ext;
	logic [32:0] diff_ext;

	assign shamt = b[4:0];

	// one extra bit catches the carry out of add and the borrow of sub
	assign sum_ext = {1'b0, a} + {1'b0, b};
	assign diff_ext = {1'b0, a} - {1'b0, b};

	always_comb begin
		result = '0;
		carry = 1'b0;
		case (op)
			ex_pkg::alu_add: begin
				result = sum_ext[31:0];
				carry = sum_ext[32];
			end
			ex_pkg::alu_sub: begin
				result = diff_ext[31:0];
				carry = diff_ext[32];
			end
			ex_pkg::alu_and: result = a & b;
			ex_pkg::alu_or: result = a | b;
			ex_pkg::alu_xor: result = a ^ b;
			ex_pkg::alu_sll: result = a << shamt;
			ex_pkg::alu_srl: result = a >> shamt;
			ex_pkg::alu_sra: result = ex_pkg::word_t'($signed(a) >>> shamt);
			ex_pkg::alu_slt: result = {31'd0, $signed(a) < $signed(b)};
			ex_pkg::alu_sltu: result = {31'd0, a < b};
			ex_pkg::alu_pass_b: result = b;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: design/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
	input logic clk,
	input logic rst_n,
	input ex_pkg::opcode_t opcode,
	input logic reg_write,
	output ex_pkg::alu_op_t alu_op
);

	logic opcode_known;

	always_comb begin
		alu_op = ex_pkg::alu_add;
		opcode_known = 1'b1;
		case (opcode)
			// loads and stores form their address with an add
			ex_pkg::op_add, ex_pkg::op_addi, ex_pkg::op_lw, ex_pkg::op_sw: begin
				alu_op = ex_pkg::alu_add;
			end
			ex_pkg::op_sub: alu_op = ex_pkg::alu_sub;
			ex_pkg::op_and, ex_pkg::op_andi: alu_op = ex_pkg::alu_and;
			ex_pkg::op_or, ex_pkg::op_ori: alu_op = ex_pkg::alu_or;
			ex_pkg::op_xor, ex_pkg::op_xori: alu_op = ex_pkg::alu_xor;
			ex_pkg::op_sll: alu_op = ex_pkg::alu_sll;
			ex_pkg::op_srl: alu_op = ex_pkg::alu_srl;
			ex_pkg::op_sra: alu_op = ex_pkg::alu_sra;
			ex_pkg::op_slt: alu_op = ex_pkg::alu_slt;
			// lui arrives with the shifted immediate already on operand B
			ex_pkg::op_lui: alu_op = ex_pkg::alu_pass_b;
			ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt,
			ex_pkg::op_ble, ex_pkg::op_bgt, ex_pkg::op_bge,
			ex_pkg::op_jr: begin
				alu_op = ex_pkg::alu_sub;
			end
			default: begin
				// bubbles land here and fall back to add
				alu_op = ex_pkg::alu_add;
				opcode_known = 1'b0;
			end
		endcase
	end

	// decode must never hand an unknown opcode a register write
	unknown_opcode_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		reg_write |-> opcode_known
	) else $error("alu_decode: unknown opcode %h with reg_write set", opcode);

endmodule

// File: design/branch_compare.sv
`timescale 1ns/1ps

module branch_compare (
	input ex_pkg::word_t a,
	input ex_pkg::word_t b,
	output logic eq,
	output logic lt
);

	ex_pkg::word_t diff_bits;
	logic low_lt;
	logic a_neg_b_pos;
	logic same_sign;

	// any differing bit breaks equality
	assign diff_bits = a ^ b;
	assign eq = ~|diff_bits;

	// magnitude part of the compare, sign bits handled below
	assign low_lt = (a[30:0] < b[30:0]);

	assign a_neg_b_pos = a[31] & ~b[31];
	assign same_sign = ~(a[31] ^ b[31]);

	// cases by sign:
	// negative against non-negative is always less
	// non-negative against negative is never less
	// equal signs fall back on the low bits, which works for two negatives
	// as well since two's complement keeps their order
	assign lt = a_neg_b_pos | (same_sign & low_lt);

endmodule

// File: design/ex_pipe_top.sv
`timescale 1ns/1ps

module ex_pipe_top (
	input logic clk,
	input logic rst_n,
	input ex_pkg::id_ex_t id_in,
	input ex_pkg::word_t wb_data,
	output ex_pkg::ex_mem_t ex_mem_out,
	output logic redirect,
	output ex_pkg::word_t redirect_pc
);

	ex_pkg::id_ex_t id_ex;
	ex_pkg::ex_mem_t ex_mem_next;
	logic mispredict;
	ex_pkg::word_t target;

	// the same mispredict that raises redirect squashes the next instruction
	id_ex_reg id_ex_reg_inst (
		.clk(clk),
		.rst_n(rst_n),
		.squash(mispredict),
		.id_in(id_in),
		.id_ex(id_ex)
	);

	ex_stage ex_stage_inst (
		.clk(clk),
		.rst_n(rst_n),
		.id_ex(id_ex),
		.fwd_ex(ex_mem_out.alu_out),
		.fwd_mem(wb_data),
		.ex_mem_next(ex_mem_next),
		.mispredict(mispredict),
		.target(target)
	);

	// EX/MEM register and the redirect strobe toward fetch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_out <= '0;
			redirect <= 1'b0;
			redirect_pc <= '0;
		end else begin
			ex_mem_out <= ex_mem_next;
			redirect <= mispredict;
			redirect_pc <= target;
		end
	end

endmodule

// File: design/ex_pkg.sv
package ex_pkg;

	// widths that carry a meaning through the stage
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [1:0] sel_a_t;
	typedef logic [2:0] sel_b_t;
	typedef logic [1:0] sel_st_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_pass_b
	} alu_op_t;

	// opcode zero stays unused so that a bubble decodes as unknown
	localparam opcode_t op_add  = 7'h01;
	localparam opcode_t op_sub  = 7'h02;
	localparam opcode_t op_and  = 7'h03;
	localparam opcode_t op_or   = 7'h04;
	localparam opcode_t op_xor  = 7'h05;
	localparam opcode_t op_sll  = 7'h06;
	localparam opcode_t op_srl  = 7'h07;
	localparam opcode_t op_sra  = 7'h08;
	localparam opcode_t op_slt  = 7'h09;
	localparam opcode_t op_addi = 7'h11;
	localparam opcode_t op_andi = 7'h13;
	localparam opcode_t op_ori  = 7'h14;
	localparam opcode_t op_xori = 7'h15;
	localparam opcode_t op_lui  = 7'h17;
	localparam opcode_t op_lw   = 7'h20;
	localparam opcode_t op_sw   = 7'h21;
	localparam opcode_t op_beq  = 7'h30;
	localparam opcode_t op_bne  = 7'h31;
	localparam opcode_t op_blt  = 7'h32;
	localparam opcode_t op_ble  = 7'h33;
	localparam opcode_t op_bgt  = 7'h34;
	localparam opcode_t op_bge  = 7'h35;
	localparam opcode_t op_jr   = 7'h38;

	// operand A sources
	localparam sel_a_t sel_a_rs1 = 2'd0;
	localparam sel_a_t sel_a_wb  = 2'd1;
	localparam sel_a_t sel_a_exm = 2'd2;
	localparam sel_a_t sel_a_pc  = 2'd3;

	// operand B sources, codes 4 to 6 all pick the immediate
	localparam sel_b_t sel_b_rs2    = 3'd0;
	localparam sel_b_t sel_b_wb     = 3'd1;
	localparam sel_b_t sel_b_exm    = 3'd2;
	localparam sel_b_t sel_b_zero   = 3'd3;
	localparam sel_b_t sel_b_imm_lo = 3'd4;
	localparam sel_b_t sel_b_imm_hi = 3'd6;
	localparam sel_b_t sel_b_one    = 3'd7;

	// store data sources, note the EX/MEM and write-back order is swapped here
	localparam sel_st_t sel_st_rs2  = 2'd0;
	localparam sel_st_t sel_st_exm  = 2'd1;
	localparam sel_st_t sel_st_wb   = 2'd2;
	localparam sel_st_t sel_st_zero = 2'd3;

	typedef struct packed {
		word_t pc;
		word_t pred_fail_pc;
		word_t rs1;
		word_t rs2;
		word_t imm;
		opcode_t opcode;
		reg_idx_t rd_ind;
		sel_a_t sel_a;
		sel_b_t sel_b;
		sel_st_t sel_st;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic predicted;
		logic is_beq;
		logic is_bne;
		logic is_blt;
		logic is_ble;
		logic is_bgt;
		logic is_bge;
	} id_ex_t;

	typedef struct packed {
		word_t alu_out;
		word_t store_data;
		reg_idx_t rd_ind;
		logic rd_nonzero;
		logic reg_write;
		logic mem_read;
		logic mem_write;
	} ex_mem_t;

endpackage

// File: design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
	input logic clk,
	input logic rst_n,
	input ex_pkg::id_ex_t id_ex,
	input ex_pkg::word_t fwd_ex,
	input ex_pkg::word_t fwd_mem,
	output ex_pkg::ex_mem_t ex_mem_next,
	output logic mispredict,
	output ex_pkg::word_t target
);

	ex_pkg::word_t oper_a;
	ex_pkg::word_t oper_b;
	ex_pkg::word_t store_data;
	ex_pkg::word_t alu_result;
	ex_pkg::alu_op_t alu_op;
	logic alu_zero;
	logic alu_carry;
	logic is_eq;
	logic is_lt;
	logic is_jr;
	logic taken;

	// fwd_ex is the previous instruction's result, fwd_mem the write-back value
	always_comb begin
		case (id_ex.sel_a)
			ex_pkg::sel_a_rs1: oper_a = id_ex.rs1;
			ex_pkg::sel_a_wb: oper_a = fwd_mem;
			ex_pkg::sel_a_exm: oper_a = fwd_ex;
			default: oper_a = id_ex.pc;
		endcase
	end

	always_comb begin
		case (id_ex.sel_b) inside
			ex_pkg::sel_b_rs2: oper_b = id_ex.rs2;
			ex_pkg::sel_b_wb: oper_b = fwd_mem;
			ex_pkg::sel_b_exm: oper_b = fwd_ex;
			ex_pkg::sel_b_zero: oper_b = '0;
			[ex_pkg::sel_b_imm_lo:ex_pkg::sel_b_imm_hi]: oper_b = id_ex.imm;
			ex_pkg::sel_b_one: oper_b = ex_pkg::word_t'(1);
			default: oper_b = id_ex.rs2;
		endcase
	end

	always_comb begin
		case (id_ex.sel_st)
			ex_pkg::sel_st_rs2: store_data = id_ex.rs2;
			ex_pkg::sel_st_exm: store_data = fwd_ex;
			ex_pkg::sel_st_wb: store_data = fwd_mem;
			default: store_data = '0;
		endcase
	end

	alu_decode alu_decode_inst (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(id_ex.opcode),
		.reg_write(id_ex.reg_write),
		.alu_op(alu_op)
	);

	alu alu_inst (
		.a(oper_a),
		.b(oper_b),
		.op(alu_op),
		.result(alu_result),
		.zero(alu_zero),
		.carry(alu_carry)
	);

	branch_compare branch_compare_inst (
		.a(oper_a),
		.b(oper_b),
		.eq(is_eq),
		.lt(is_lt)
	);

	assign is_jr = (id_ex.opcode == ex_pkg::op_jr);

	// a bubble has no flags and predicted low, so it never mispredicts
	assign taken = (id_ex.is_beq & is_eq) | (id_ex.is_bne & ~is_eq) |
		(id_ex.is_blt & is_lt) | (id_ex.is_ble & (is_lt | is_eq)) |
		(id_ex.is_bgt & ~(is_lt | is_eq)) | (id_ex.is_bge & ~is_lt) | is_jr;

	assign mispredict = (taken != id_ex.predicted);
	assign target = is_jr ? oper_a : id_ex.pred_fail_pc;

	always_comb begin
		ex_mem_next.alu_out = alu_result;
		ex_mem_next.store_data = store_data;
		ex_mem_next.rd_ind = id_ex.rd_ind;
		ex_mem_next.rd_nonzero = (id_ex.rd_ind != '0);
		ex_mem_next.reg_write = id_ex.reg_write;
		ex_mem_next.mem_read = id_ex.mem_read;
		ex_mem_next.mem_write = id_ex.mem_write;
	end

	one_branch_flag: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0({id_ex.is_beq, id_ex.is_bne, id_ex.is_blt,
			id_ex.is_ble, id_ex.is_bgt, id_ex.is_bge}) &&
		!(id_ex.mem_read && id_ex.mem_write)
	) else $error("ex_stage: conflicting branch or memory flags");

	// on a subtract the ALU flags must agree with the comparator, the borrow
	// only tracks lt while both operands share a sign
	cmp_matches_alu: assert property (
		@(posedge clk) disable iff (!rst_n)
		(alu_op == ex_pkg::alu_sub) |->
			(alu_zero == is_eq) && ((oper_a[31] != oper_b[31]) || (alu_carry == is_lt))
	) else $error("ex_stage: comparator disagrees with ALU flags");

endmodule

// File: design/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input logic clk,
	input logic rst_n,
	input logic squash,
	input ex_pkg::id_ex_t id_in,
	output ex_pkg::id_ex_t id_ex
);

	// a bubble is all zeros, which clears every control bit and branch flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (squash) begin
			// the instruction fetched down the wrong path is dropped here
			id_ex <= '0;
		end else begin
			id_ex <= id_in;
		end
	end

endmodule

// File: ex_pipe_top.f
design/ex_pkg.sv
design/alu_decode.sv
design/alu.sv
design/branch_compare.sv
design/ex_stage.sv
design/id_ex_reg.sv
design/ex_pipe_top.sv
testbench/ex_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f ex_pipe_top.f \
	--top-module ex_pipe_tb \
	-o ex_pipe_sim

if ! ./obj_dir/ex_pipe_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi
cat sim.log

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

// File: testbench/ex_pipe_tb.sv
`timescale 1ns/1ps

module ex_pipe_tb;

	localparam int seed = 25941;
	localparam int num_instr = 2000;
	localparam int reset_cycles = 5;
	localparam int clk_period = 8;

	logic clk;
	logic rst_n;
	ex_pkg::id_ex_t id_in;
	ex_pkg::word_t wb_data;
	ex_pkg::ex_mem_t ex_mem_out;
	logic redirect;
	ex_pkg::word_t redirect_pc;

	// model copies of the ID/EX register and of the registered outputs
	ex_pkg::id_ex_t model_id_ex;
	ex_pkg::ex_mem_t model_ex_mem;
	logic model_redirect;
	ex_pkg::word_t model_redirect_pc;

	int error_count;
	int check_count;

	ex_pkg::opcode_t op_list [23] = '{
		ex_pkg::op_add, ex_pkg::op_sub, ex_pkg::op_and, ex_pkg::op_or, ex_pkg::op_xor,
		ex_pkg::op_sll, ex_pkg::op_srl, ex_pkg::op_sra, ex_pkg::op_slt, ex_pkg::op_addi,
		ex_pkg::op_andi, ex_pkg::op_ori, ex_pkg::op_xori, ex_pkg::op_lui, ex_pkg::op_lw,
		ex_pkg::op_sw, ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt, ex_pkg::op_ble,
		ex_pkg::op_bgt, ex_pkg::op_bge, ex_pkg::op_jr
	};

	ex_pipe_top ex_pipe_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.id_in(id_in),
		.wb_data(wb_data),
		.ex_mem_out(ex_mem_out),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// equal values and values around the sign bit stress the signed compare
	function automatic ex_pkg::word_t sign_edge_value();
		case (3'($urandom % 6))
			3'd0: return 32'h0000_0000;
			3'd1: return 32'h0000_0001;
			3'd2: return 32'h7fff_ffff;
			3'd3: return 32'h8000_0000;
			3'd4: return 32'hffff_ffff;
			default: return 32'h8000_0001;
		endcase
	endfunction

	function automatic ex_pkg::word_t expected_alu(ex_pkg::opcode_t op, ex_pkg::word_t a,
		ex_pkg::word_t b);
		case (op)
			ex_pkg::op_sub, ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt, ex_pkg::op_ble,
			ex_pkg::op_bgt, ex_pkg::op_bge, ex_pkg::op_jr: return a - b;
			ex_pkg::op_and, ex_pkg::op_andi: return a & b;
			ex_pkg::op_or, ex_pkg::op_ori: return a | b;
			ex_pkg::op_xor, ex_pkg::op_xori: return a ^ b;
			ex_pkg::op_sll: return a << b[4:0];
			ex_pkg::op_srl: return a >> b[4:0];
			ex_pkg::op_sra: return ex_pkg::word_t'($signed(a) >>> b[4:0]);
			ex_pkg::op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ex_pkg::op_lui: return b;
			default: return a + b;
		endcase
	endfunction

	task automatic make_instr(output ex_pkg::id_ex_t ins);
		ex_pkg::opcode_t op;
		logic branch_op;
		ins = '0;
		op = op_list[5'($urandom % 23)];
		ins.opcode = op;
		ins.pc = $urandom;
		ins.pred_fail_pc = $urandom;
		ins.rs1 = $urandom;
		ins.rs2 = $urandom;
		ins.imm = $urandom;
		ins.rd_ind = ex_pkg::reg_idx_t'($urandom);
		ins.sel_a = ex_pkg::sel_a_t'($urandom);
		ins.sel_b = ex_pkg::sel_b_t'($urandom);
		ins.sel_st = ex_pkg::sel_st_t'($urandom);
		ins.predicted = 1'($urandom);
		ins.is_beq = (op == ex_pkg::op_beq);
		ins.is_bne = (op == ex_pkg::op_bne);
		ins.is_blt = (op == ex_pkg::op_blt);
		ins.is_ble = (op == ex_pkg::op_ble);
		ins.is_bgt = (op == ex_pkg::op_bgt);
		ins.is_bge = (op == ex_pkg::op_bge);
		branch_op = ins.is_beq | ins.is_bne | ins.is_blt | ins.is_ble | ins.is_bgt | ins.is_bge;
		ins.mem_read = (op == ex_pkg::op_lw);
		ins.mem_write = (op == ex_pkg::op_sw);
		ins.reg_write = !branch_op && (op != ex_pkg::op_jr) && (op != ex_pkg::op_sw);
		if (branch_op && 1'($urandom)) begin
			ins.sel_a = 2'd0;
			ins.sel_b = 3'd0;
			ins.rs1 = sign_edge_value();
			ins.rs2 = 1'($urandom) ? ins.rs1 : sign_edge_value();
		end
	endtask

	// one execute step of the model, which forwards its own previous alu_out as fwd_ex
	task automatic model_step(input ex_pkg::id_ex_t ie, input ex_pkg::word_t fwd_ex,
		input ex_pkg::word_t fwd_wb, output ex_pkg::ex_mem_t nxt, output logic mis,
		output ex_pkg::word_t tgt);
		ex_pkg::word_t a;
		ex_pkg::word_t b;
		logic eq;
		logic lt;
		logic taken;
		nxt = '0;
		case (ie.sel_a)
			2'd0: a = ie.rs1;
			2'd1: a = fwd_wb;
			2'd2: a = fwd_ex;
			default: a = ie.pc;
		endcase
		case (ie.sel_b)
			3'd0: b = ie.rs2;
			3'd1: b = fwd_wb;
			3'd2: b = fwd_ex;
			3'd3: b = 32'd0;
			3'd7: b = 32'd1;
			default: b = ie.imm;
		endcase
		case (ie.sel_st)
			2'd0: nxt.store_data = ie.rs2;
			2'd1: nxt.store_data = fwd_ex;
			2'd2: nxt.store_data = fwd_wb;
			default: nxt.store_data = 32'd0;
		endcase
		nxt.alu_out = expected_alu(ie.opcode, a, b);
		nxt.rd_ind = ie.rd_ind;
		nxt.rd_nonzero = (ie.rd_ind != 5'd0);
		nxt.reg_write = ie.reg_write;
		nxt.mem_read = ie.mem_read;
		nxt.mem_write = ie.mem_write;
		eq = (a == b);
		lt = ($signed(a) < $signed(b));
		taken = (ie.is_beq && eq) || (ie.is_bne && !eq) || (ie.is_blt && lt) ||
			(ie.is_ble && (lt || eq)) || (ie.is_bgt && !lt && !eq) || (ie.is_bge && !lt) ||
			(ie.opcode == ex_pkg::op_jr);
		mis = (taken != ie.predicted);
		tgt = (ie.opcode == ex_pkg::op_jr) ? a : ie.pred_fail_pc;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		compare_value("ex_mem_out.alu_out", ex_mem_out.alu_out, model_ex_mem.alu_out);
		compare_value("ex_mem_out.store_data", ex_mem_out.store_data, model_ex_mem.store_data);
		compare_value("ex_mem_out.rd_ind", 32'(ex_mem_out.rd_ind), 32'(model_ex_mem.rd_ind));
		compare_value("ex_mem_out.rd_nonzero", 32'(ex_mem_out.rd_nonzero),
			32'(model_ex_mem.rd_nonzero));
		compare_value("ex_mem_out.reg_write", 32'(ex_mem_out.reg_write),
			32'(model_ex_mem.reg_write));
		compare_value("ex_mem_out.mem_read", 32'(ex_mem_out.mem_read), 32'(model_ex_mem.mem_read));
		compare_value("ex_mem_out.mem_write", 32'(ex_mem_out.mem_write),
			32'(model_ex_mem.mem_write));
		compare_value("redirect", 32'(redirect), 32'(model_redirect));
		compare_value("redirect_pc", redirect_pc, model_redirect_pc);
	endtask

	initial begin
		ex_pkg::id_ex_t ins;
		ex_pkg::ex_mem_t nxt;
		logic mis;
		ex_pkg::word_t tgt;
		void'($urandom(seed));
		rst_n = 1'b0;
		id_in = '0;
		wb_data = '0;
		model_id_ex = '0;
		model_ex_mem = '0;
		model_redirect = 1'b0;
		model_redirect_pc = '0;
		error_count = 0;
		check_count = 0;
		// everything registered must read zero while reset is held
		repeat (reset_cycles) begin
			@(negedge clk);
			check_outputs();
		end
		@(posedge clk);
		rst_n <= 1'b1;
		// two extra cycles drain the last instructions out of the pipe
		for (int n = 0; n < num_instr + 2; n++) begin
			@(posedge clk);
			model_step(model_id_ex, model_ex_mem.alu_out, wb_data, nxt, mis, tgt);
			// a mispredict squashes whatever sits on id_in at this edge
			model_id_ex = mis ? '0 : id_in;
			model_ex_mem = nxt;
			model_redirect = mis;
			model_redirect_pc = tgt;
			if (n < num_instr) begin
				make_instr(ins);
				id_in <= ins;
			end else begin
				id_in <= '0;
			end
			wb_data <= $urandom;
			@(negedge clk);
			check_outputs();
		end
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		#((num_instr + reset_cycles + 20) * clk_period);
		$display("watchdog timeout: the run did not finish in time");
		$display("Errors found");
		$finish;
	end

endmodule
